/* logic/exec_pkg.sv */
/*
 * Shared definitions for the integer execute unit: data and address widths,
 * command word layout and the ALU opcode encoding. Modules import it inside
 * their bodies and use scoped names in their port lists.
 */
package exec_pkg;

  // Data path and register file sizes
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  //////////////////////////////
  // Command word layout
  //////////////////////////////
  // [31:28] opcode, [27:23] rd, [22:18] rs1, [17:13] rs2, [12:0] immediate
  localparam int unsigned CMD_W   = 32;
  localparam int unsigned OP_W    = 4;
  localparam int unsigned OP_LSB  = 28;
  localparam int unsigned RD_LSB  = 23;
  localparam int unsigned RS1_LSB = 18;
  localparam int unsigned RS2_LSB = 13;
  localparam int unsigned IMM_W   = 13;

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  // Codes 8 to 15 are not defined and decode as illegal
  typedef enum logic [OP_W-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    // Load of the sign-extended immediate
    OP_LDI = 4'd7
  } alu_op_e;

endpackage

/* logic/clock_gate.sv */
/*
 * Behavioral clock-gating cell. The enable is held in a latch that is open
 * while the input clock is low, so the gated clock never glitches.
 */
`timescale 1ns/100ps

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latched;

  // Enable latch, transparent in the low phase of clk_i
  // Scan mode keeps the gate open regardless of en_i
  always_latch begin : en_latch
    if (!clk_i) begin
      en_latched = en_i | test_en_i;
    end
  end

  // Enable is stable for the whole high phase
  assign clk_o = clk_i & en_latched;

endmodule

/* logic/latch_regfile.sv */
/*
 * Latch-based register file, two combinational read ports and one write port.
 * Word 0 reads zero. A write presented before a rising edge is sampled there
 * and lands in its word latch during the low phase that follows.
 */
`timescale 1ns/100ps

module latch_regfile (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            test_en_i,
  // Read port A
  input  logic [exec_pkg::REG_ADDR_W-1:0] raddr_a_i,
  output logic [exec_pkg::XLEN-1:0]       rdata_a_o,
  // Read port B
  input  logic [exec_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [exec_pkg::XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic [exec_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [exec_pkg::XLEN-1:0]       wdata_i,
  input  logic                            we_i
);

  import exec_pkg::*;

  // Storage, word 0 is constant zero
  logic [XLEN-1:0]       mem [NUM_REGS];

  logic                  clk_we;
  logic                  clk_n;
  logic [XLEN-1:0]       wdata_q;
  logic [REG_ADDR_W-1:0] waddr_q;
  logic                  we_q;
  logic [NUM_REGS-1:1]   word_en;
  logic [NUM_REGS-1:1]   word_pulse;
  logic [NUM_REGS-1:1]   mem_clocks;

  //////////////////////////////
  // Read ports
  //////////////////////////////
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

  //////////////////////////////
  // Write sampling
  //////////////////////////////
  // Global gate, ticks only in cycles that carry a write
  clock_gate u_cg_we_global (
    .clk_i     (clk_i),
    .en_i      (we_i),
    .test_en_i (test_en_i),
    .clk_o     (clk_we)
  );

  // Data and address of the pending write
  // Cleared data lets reset flush zeros into every word
  always_ff @(posedge clk_we or negedge rst_ni) begin : sample_wdata
    if (!rst_ni) begin
      wdata_q <= '0;
      waddr_q <= '0;
    end else if (we_i) begin
      wdata_q <= wdata_i;
      waddr_q <= waddr_i;
    end
  end

  // Marks the cycle in which the sampled write goes into storage
  always_ff @(posedge clk_i or negedge rst_ni) begin : sample_we
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else begin
      we_q <= we_i;
    end
  end

  //////////////////////////////
  // Write address decoder
  //////////////////////////////
  // One-hot select from the sampled address, word 0 has no select
  // Reset opens every word so the latches load the cleared data
  always_comb begin : write_decode
    for (int k = 1; k < NUM_REGS; k++) begin
      word_en[k] = (we_q && (waddr_q == REG_ADDR_W'(k))) || !rst_ni;
    end
  end

  //////////////////////////////
  // Word clock gates
  //////////////////////////////
  // Gates run on the inverted clock, so the enable settles in the high phase
  // and the pulse covers the low phase after the sampling edge
  assign clk_n = ~clk_i;

  for (genvar g = 1; g < NUM_REGS; g++) begin : gen_word_gate
    clock_gate u_cg_word (
      .clk_i     (clk_n),
      .en_i      (word_en[g]),
      .test_en_i (test_en_i),
      .clk_o     (word_pulse[g])
    );

    // Active-low word clock, idles high
    assign mem_clocks[g] = ~word_pulse[g];
  end

  //////////////////////////////
  // Storage latches
  //////////////////////////////
  // Transparent while the word clock is low
  // Select also qualifies the latch, so an open scan clock leaves words alone
  always_latch begin : word_latches
    mem[0] = '0;
    for (int k = 1; k < NUM_REGS; k++) begin
      if (!mem_clocks[k] && word_en[k]) begin
        mem[k] = wdata_q;
      end
    end
  end

endmodule

/* logic/cmd_decoder.sv */
/*
 * Command word decoder. Splits a command into opcode, register addresses and
 * a sign-extended immediate, and flags opcodes outside the defined set.
 */
`timescale 1ns/100ps

module cmd_decoder (
  input  logic [exec_pkg::CMD_W-1:0]      cmd_i,
  output exec_pkg::alu_op_e               op_o,
  output logic [exec_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [exec_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [exec_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [exec_pkg::XLEN-1:0]       imm_o,
  output logic                            legal_o
);

  import exec_pkg::*;

  logic [OP_W-1:0]  op_raw;
  logic [IMM_W-1:0] imm_raw;

  //////////////////////////////
  // Field extraction
  //////////////////////////////
  assign op_raw  = cmd_i[OP_LSB +: OP_W];
  assign imm_raw = cmd_i[IMM_W-1:0];

  // Raw code kept as is, also for undefined values
  assign op_o = alu_op_e'(op_raw);

  // Register addresses
  assign rd_o  = cmd_i[RD_LSB +: REG_ADDR_W];
  assign rs1_o = cmd_i[RS1_LSB +: REG_ADDR_W];
  assign rs2_o = cmd_i[RS2_LSB +: REG_ADDR_W];

  // Immediate, top bit copied up to XLEN
  assign imm_o = {{(XLEN - IMM_W){imm_raw[IMM_W-1]}}, imm_raw};

  //////////////////////////////
  // Opcode check
  //////////////////////////////
  always_comb begin : legal_check
    case (op_raw)
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLL,
      OP_SRL,
      OP_LDI: begin
        legal_o = 1'b1;
      end
      // Codes 8 to 15
      default: begin
        legal_o = 1'b0;
      end
    endcase
  end

endmodule

/* logic/int_alu.sv */
/*
 * Combinational integer ALU. Add and subtract wrap, logic ops are bitwise,
 * shifts are logical with the amount in the low bits of b_i. Load immediate
 * passes imm_i through; undefined opcodes give zero.
 */
`timescale 1ns/100ps

module int_alu (
  input  exec_pkg::alu_op_e         op_i,
  input  logic [exec_pkg::XLEN-1:0] a_i,
  input  logic [exec_pkg::XLEN-1:0] b_i,
  input  logic [exec_pkg::XLEN-1:0] imm_i,
  output logic [exec_pkg::XLEN-1:0] result_o
);

  import exec_pkg::*;

  logic [SHAMT_W-1:0] shamt;

  // Shift amount from the second operand
  assign shamt = b_i[SHAMT_W-1:0];

  always_comb begin : alu_core
    case (op_i)
      // Arithmetic, modulo 2^XLEN
      OP_ADD: begin
        result_o = a_i + b_i;
      end
      OP_SUB: begin
        result_o = a_i - b_i;
      end
      // Bitwise logic
      OP_AND: begin
        result_o = a_i & b_i;
      end
      OP_OR: begin
        result_o = a_i | b_i;
      end
      OP_XOR: begin
        result_o = a_i ^ b_i;
      end
      // Logical shifts, zero fill
      OP_SLL: begin
        result_o = a_i << shamt;
      end
      OP_SRL: begin
        result_o = a_i >> shamt;
      end
      // Immediate load, already sign-extended
      OP_LDI: begin
        result_o = imm_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* logic/exec_unit.sv */
/*
 * Execute unit top level. Takes one command per cycle, reads both operands,
 * computes in the ALU and writes back to the latch register file. The result
 * and its destination appear on registered outputs one cycle later.
 */
`timescale 1ns/100ps

module exec_unit (
  input  logic                            clk_int,
  input  logic                            rst_ni,
  input  logic                            test_en_i,
  // Command input
  input  logic                            cmd_valid_i,
  input  logic [exec_pkg::CMD_W-1:0]      cmd_i,
  // Result output
  output logic                            res_valid_o,
  output logic [exec_pkg::XLEN-1:0]       res_o,
  output logic [exec_pkg::REG_ADDR_W-1:0] res_rd_o,
  output logic                            illegal_o
);

  import exec_pkg::*;

  alu_op_e               op;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       imm;
  logic                  legal;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic [XLEN-1:0]       alu_result;
  logic                  rf_we;

  //////////////////////////////
  // Decode and operand read
  //////////////////////////////
  cmd_decoder u_decoder (
    .cmd_i   (cmd_i),
    .op_o    (op),
    .rd_o    (rd),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .imm_o   (imm),
    .legal_o (legal)
  );

  // Accepted legal command, rd 0 is dropped inside the register file
  assign rf_we = cmd_valid_i && legal;

  latch_regfile u_regfile (
    .clk_i     (clk_int),
    .rst_ni    (rst_ni),
    .test_en_i (test_en_i),
    .raddr_a_i (rs1),
    .rdata_a_o (rdata_a),
    .raddr_b_i (rs2),
    .rdata_b_o (rdata_b),
    .waddr_i   (rd),
    .wdata_i   (alu_result),
    .we_i      (rf_we)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  int_alu u_alu (
    .op_i     (op),
    .a_i      (rdata_a),
    .b_i      (rdata_b),
    .imm_i    (imm),
    .result_o (alu_result)
  );

  //////////////////////////////
  // Result outputs
  //////////////////////////////
  // One-cycle pulses for completion and bad opcode
  always_ff @(posedge clk_int or negedge rst_ni) begin : out_pulses
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      res_valid_o <= rf_we;
      illegal_o   <= cmd_valid_i && !legal;
    end
  end

  // Result and destination hold until the next accepted command
  always_ff @(posedge clk_int) begin : out_payload
    if (rf_we) begin
      res_o    <= alu_result;
      res_rd_o <= rd;
    end
  end

endmodule

/* dv/exec_model.svh */
/*
 * Testbench helpers for the execute unit: LFSR step, command word builder and
 * a reference ALU written from the opcode rules. Included in the testbench body.
 */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Fibonacci LFSR, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// Packs the fields at the positions the package defines
function automatic logic [CMD_W-1:0] build_cmd(input logic [3:0] op, input logic [4:0] rd,
    input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] imm);
  logic [CMD_W-1:0] c;
  c = '0;
  c[OP_LSB +: OP_W]        = op;
  c[RD_LSB +: REG_ADDR_W]  = rd;
  c[RS1_LSB +: REG_ADDR_W] = rs1;
  c[RS2_LSB +: REG_ADDR_W] = rs2;
  c[IMM_W-1:0]             = imm;
  return c;
endfunction

// Expected result, wraps modulo 2^32, shift amount from b[4:0]
function automatic logic [31:0] model_alu(input logic [3:0] op, input logic [31:0] a,
    input logic [31:0] b, input logic [12:0] imm);
  case (op)
    OP_ADD: return a + b;
    OP_SUB: return a - b;
    OP_AND: return a & b;
    OP_OR:  return a | b;
    OP_XOR: return a ^ b;
    OP_SLL: return a << b[4:0];
    OP_SRL: return a >> b[4:0];
    // Immediate with bit 12 copied upward
    OP_LDI: return {{19{imm[12]}}, imm};
    default: return 32'h0;
  endcase
endfunction

`endif

/* dv/exec_unit_tb.sv */
/*
 * Testbench for the execute unit. Drives directed and LFSR-random commands,
 * keeps a register model and compares every result one cycle later.
 */
`timescale 1ns/100ps

module exec_unit_tb;

  import exec_pkg::*;
  `include "exec_model.svh"

  localparam int NUM_RANDOM = 400;
  localparam int TIMEOUT    = 8;

  logic                  clk_int;
  logic                  rst_ni;
  logic                  test_en_i;
  logic                  cmd_valid_i;
  logic [CMD_W-1:0]      cmd_i;
  logic                  res_valid_o;
  logic [XLEN-1:0]       res_o;
  logic [REG_ADDR_W-1:0] res_rd_o;
  logic                  illegal_o;

  logic [31:0]           lfsr_state;
  logic [XLEN-1:0]       model_regs [NUM_REGS];
  // Expectations for the command in flight
  logic                  exp_valid_q [$];
  logic                  exp_illegal_q [$];
  logic [XLEN-1:0]       exp_res_q [$];
  logic [4:0]            exp_rd_q [$];
  string                 test_name;
  int                    errors;
  int                    timeouts;

  exec_unit DUT (
    .clk_int     (clk_int),
    .rst_ni      (rst_ni),
    .test_en_i   (test_en_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_rd_o    (res_rd_o),
    .illegal_o   (illegal_o)
  );

  always #2 clk_int = ~clk_int;

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] nonzero_reg();
    logic [4:0] r;
    r = 5'(rand_bits(5));
    return (r == 5'd0) ? 5'd1 : r;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h", test_name, sig, exp, act);
    errors++;
  endtask

  //////////////////////////////
  // Issue one cycle and check
  //////////////////////////////
  task automatic issue(input logic valid, input logic [CMD_W-1:0] cmd);
    logic [3:0]      op;
    logic [4:0]      rd;
    logic            legal;
    logic            ev;
    logic            ei;
    logic            done;
    logic [XLEN-1:0] result;
    int              cycles;
    op     = cmd[OP_LSB +: OP_W];
    rd     = cmd[RD_LSB +: REG_ADDR_W];
    legal  = (op < 4'd8);
    // Operands from the model state before this command
    result = model_alu(op, model_regs[cmd[RS1_LSB +: REG_ADDR_W]],
                       model_regs[cmd[RS2_LSB +: REG_ADDR_W]], cmd[IMM_W-1:0]);
    cmd_valid_i = valid;
    cmd_i       = cmd;
    exp_valid_q.push_back(valid && legal);
    exp_illegal_q.push_back(valid && !legal);
    exp_res_q.push_back(result);
    exp_rd_q.push_back(rd);
    if (valid && legal && rd != 5'd0) begin
      model_regs[rd] = result;
    end
    @(posedge clk_int);
    #1;
    cmd_valid_i = 1'b0;
    ev          = exp_valid_q.pop_front();
    ei          = exp_illegal_q.pop_front();
    cycles      = 1;
    done        = (ev && res_valid_o) || (ei && illegal_o) || !(ev || ei);
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk_int);
      #1;
      cycles++;
      done = (ev && res_valid_o) || (ei && illegal_o);
    end
    if (!done) begin
      $display("Timeout in %s: no response from the DUT within %0d cycles", test_name,
               TIMEOUT);
      timeouts++;
    end else if (cycles != 1) begin
      report_mismatch("latency", 32'd1, 32'(cycles));
    end
    if (res_valid_o !== ev) report_mismatch("res_valid_o", 32'(ev), 32'(res_valid_o));
    if (illegal_o !== ei) report_mismatch("illegal_o", 32'(ei), 32'(illegal_o));
    result = exp_res_q.pop_front();
    rd     = exp_rd_q.pop_front();
    // Payload only means something with a result pulse
    if (ev && res_o !== result) report_mismatch("res_o", result, res_o);
    if (ev && res_rd_o !== rd) report_mismatch("res_rd_o", 32'(rd), 32'(res_rd_o));
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    logic [4:0] prev;
    logic [4:0] rd;
    clk_int     = 1'b0;
    rst_ni      = 1'b1;
    test_en_i   = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    errors      = 0;
    timeouts    = 0;
    lfsr_state  = 32'h266683e7;
    for (int k = 0; k < NUM_REGS; k++) model_regs[k] = '0;

    // Reset held over four rising edges
    #1;
    rst_ni    = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk_int);
    #1;
    if (res_valid_o !== 1'b0) report_mismatch("res_valid_o", 32'd0, 32'(res_valid_o));
    if (illegal_o !== 1'b0) report_mismatch("illegal_o", 32'd0, 32'(illegal_o));
    rst_ni = 1'b1;

    // Cleared registers add up to zero
    test_name = "first_add";
    issue(1'b1, build_cmd(OP_ADD, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                          13'd0));

    test_name = "fill_ldi";
    for (int k = 1; k < NUM_REGS; k++) begin
      issue(1'b1, build_cmd(OP_LDI, 5'(k), 5'd0, 5'd0, 13'(rand_bits(13))));
    end

    test_name = "random_ops";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      issue(1'b1, build_cmd(4'(rand_bits(3)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                            5'(rand_bits(5)), 13'(rand_bits(13))));
    end

    // Result is still reported while register 0 keeps zero
    test_name = "write_r0";
    for (int n = 0; n < 20; n++) begin
      issue(1'b1, build_cmd(4'(rand_bits(3)), 5'd0, nonzero_reg(), nonzero_reg(),
                            13'(rand_bits(13))));
      issue(1'b1, build_cmd(OP_OR, nonzero_reg(), 5'd0, 5'd0, 13'd0));
    end

    // Each rs1 is the rd of the command one cycle earlier
    test_name = "dep_chain";
    for (int c = 0; c < 10; c++) begin
      prev = nonzero_reg();
      for (int s = 0; s < 12; s++) begin
        rd = nonzero_reg();
        issue(1'b1, build_cmd(4'(rand_bits(3)), rd, prev, 5'(rand_bits(5)), 13'(rand_bits(13))));
        prev = rd;
      end
    end

    test_name = "illegal_op";
    for (int n = 0; n < 20; n++) begin
      rd = nonzero_reg();
      issue(1'b1, build_cmd(4'(8 + rand_bits(3)), rd, nonzero_reg(), nonzero_reg(),
                            13'(rand_bits(13))));
      issue(1'b1, build_cmd(OP_OR, 5'd0, rd, 5'd0, 13'd0));
    end

    // Scan mode opens every gate while cmd_i carries random bits without a strobe
    test_name = "scan_idle";
    test_en_i = 1'b1;
    for (int n = 0; n < 16; n++) issue(1'b0, rand_bits(32));
    test_en_i = 1'b0;
    for (int k = 0; k < NUM_REGS; k++) begin
      issue(1'b1, build_cmd(OP_OR, 5'd0, 5'(k), 5'd0, 13'd0));
    end

    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* exec_unit.f */
+incdir+dv
logic/exec_pkg.sv
logic/clock_gate.sv
logic/latch_regfile.sv
logic/cmd_decoder.sv
logic/int_alu.sv
logic/exec_unit.sv
dv/exec_unit_tb.sv

/* Makefile */
# Verilator build and run for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= exec_unit.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
